// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

  // word and field widths
  localparam int DataWidth    = 32;  // data and instruction words
  localparam int RegAddrWidth = 5;   // 32 registers
  localparam int AluOpWidth   = 3;

  // major opcodes, instr[31:26]
  localparam logic [5:0] OpRType = 6'h00;
  localparam logic [5:0] OpLw    = 6'h23;
  localparam logic [5:0] OpSw    = 6'h2B;

  // funct codes for r-format
  localparam logic [5:0] FnAdd = 6'h20;
  localparam logic [5:0] FnSub = 6'h22;
  localparam logic [5:0] FnAnd = 6'h24;
  localparam logic [5:0] FnOr  = 6'h25;
  localparam logic [5:0] FnSll = 6'h00;
  localparam logic [5:0] FnSrl = 6'h02;

  // alu operation select
  localparam logic [AluOpWidth-1:0] AluAdd = 3'd0;
  localparam logic [AluOpWidth-1:0] AluSub = 3'd1;
  localparam logic [AluOpWidth-1:0] AluAnd = 3'd2;
  localparam logic [AluOpWidth-1:0] AluOr  = 3'd3;
  localparam logic [AluOpWidth-1:0] AluSll = 3'd4;
  localparam logic [AluOpWidth-1:0] AluSrl = 3'd5;

  // one instruction word, two ways to read it
  typedef union packed {
    struct packed {
      logic [5:0]              opcode;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rt;
      logic [RegAddrWidth-1:0] rd;     // destination for r-format
      logic [4:0]              shamt;  // sll/srl amount
      logic [5:0]              funct;
    } rFields;
    struct packed {
      logic [5:0]              opcode;
      logic [RegAddrWidth-1:0] rs;     // base register
      logic [RegAddrWidth-1:0] rt;     // lw dest / sw data
      logic [15:0]             imm16;  // signed offset
    } iFields;
  } instrWord_t;

endpackage

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [RegAddrWidth-1:0] rsAddr,
  input  logic [RegAddrWidth-1:0] rtAddr,
  output logic [DataWidth-1:0]    rsData,
  output logic [DataWidth-1:0]    rtData,
  input  logic                    wrEn,
  input  logic [RegAddrWidth-1:0] wrAddr,
  input  logic [DataWidth-1:0]    wrData
);

  localparam int NumRegs = 1 << RegAddrWidth;

  logic [DataWidth-1:0] regs [NumRegs];

  // reset loads register i with i
  // r0 is an ordinary register here, no hardwired zero
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < NumRegs; i++)
      begin
        regs[i] <= DataWidth'(i);
      end
    end
    else if (wrEn)
    begin
      regs[wrAddr] <= wrData;  // lands at the edge
    end
  end

  // read ports are plain muxes
  assign rsData = regs[rsAddr];
  assign rtData = regs[rtAddr];  // same-cycle write not bypassed, decode forwards

endmodule

`default_nettype wire

// File: dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory import cpuPkg::*; #(
  parameter int MemDepth = 256  // power of two
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(MemDepth)-1:0]  addr,
  input  logic                         wrEn,
  input  logic [DataWidth-1:0]         wrData,
  output logic [DataWidth-1:0]         rdData
);

  logic [DataWidth-1:0] mem [MemDepth];

  // word i starts out holding i
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < MemDepth; i++)
      begin
        mem[i] <= DataWidth'(i);
      end
    end
    else if (wrEn)
    begin
      mem[addr] <= wrData;
    end
  end

  assign rdData = mem[addr];  // async read, lw data in the same cycle

endmodule

`default_nettype wire

// File: decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage import cpuPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  instrWord_t              instr,
  input  logic                    instrValid,
  output logic [RegAddrWidth-1:0] rsAddr,
  output logic [RegAddrWidth-1:0] rtAddr,
  input  logic [DataWidth-1:0]    rsData,
  input  logic [DataWidth-1:0]    rtData,
  input  logic                    exFwdValid,
  input  logic [RegAddrWidth-1:0] exFwdReg,
  input  logic [DataWidth-1:0]    exFwdData,
  input  logic                    resValid,
  input  logic [RegAddrWidth-1:0] resReg,
  input  logic [DataWidth-1:0]    resData,
  output logic                    exValid,
  output logic                    exRegWrite,
  output logic                    exMemWrite,
  output logic                    exMemToReg,
  output logic                    exAluSrcImm,
  output logic [AluOpWidth-1:0]   exAluOp,
  output logic [RegAddrWidth-1:0] exDest,
  output logic [DataWidth-1:0]    exOpA,
  output logic [DataWidth-1:0]    exOpB,
  output logic [DataWidth-1:0]    exImm,
  output logic [4:0]              exShamt
);

  instrWord_t            decInstr;  // decode register
  logic                  decValid;
  logic                  known;     // opcode and funct recognized
  logic                  regWrite;
  logic                  memWrite;
  logic                  memToReg;
  logic                  aluSrcImm;
  logic [AluOpWidth-1:0] aluOp;
  logic [RegAddrWidth-1:0] dest;
  logic [DataWidth-1:0]  immExt;
  logic [DataWidth-1:0]  opA;
  logic [DataWidth-1:0]  opB;

  // newest value wins: execute, then result reg, then register file
  function automatic logic [DataWidth-1:0] pickOperand(
    input logic [RegAddrWidth-1:0] addr,
    input logic [DataWidth-1:0]    rfVal,
    input logic                    fwdExValid,
    input logic [RegAddrWidth-1:0] fwdExReg,
    input logic [DataWidth-1:0]    fwdExData,
    input logic                    fwdResValid,
    input logic [RegAddrWidth-1:0] fwdResReg,
    input logic [DataWidth-1:0]    fwdResData
  );
    if (fwdExValid && fwdExReg == addr)
      return fwdExData;
    else if (fwdResValid && fwdResReg == addr)
      return fwdResData;
    return rfVal;
  endfunction

  // decode register, a bubble just carries valid low
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      decInstr <= '0;
      decValid <= 1'b0;
    end
    else
    begin
      decInstr <= instr;
      decValid <= instrValid;
    end
  end

  assign rsAddr = decInstr.rFields.rs;
  assign rtAddr = decInstr.rFields.rt;
  assign immExt = {{(DataWidth-16){decInstr.iFields.imm16[15]}}, decInstr.iFields.imm16};

  // control decode
  always_comb
  begin
    known     = 1'b0;
    regWrite  = 1'b0;
    memWrite  = 1'b0;
    memToReg  = 1'b0;
    aluSrcImm = 1'b0;
    aluOp     = AluAdd;               // lw/sw address add
    dest      = decInstr.iFields.rt;  // i-format target
    case (decInstr.rFields.opcode)
      OpRType:
      begin
        regWrite = 1'b1;
        dest     = decInstr.rFields.rd;
        known    = 1'b1;
        case (decInstr.rFields.funct)
          FnAdd:   aluOp = AluAdd;
          FnSub:   aluOp = AluSub;
          FnAnd:   aluOp = AluAnd;
          FnOr:    aluOp = AluOr;
          FnSll:   aluOp = AluSll;
          FnSrl:   aluOp = AluSrl;
          default: known = 1'b0;  // unknown funct becomes a bubble
        endcase
      end
      OpLw:
      begin
        known     = 1'b1;
        regWrite  = 1'b1;
        memToReg  = 1'b1;
        aluSrcImm = 1'b1;
      end
      OpSw:
      begin
        known     = 1'b1;
        memWrite  = 1'b1;
        aluSrcImm = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  always_comb
  begin
    opA = pickOperand(rsAddr, rsData, exFwdValid, exFwdReg, exFwdData,
                      resValid, resReg, resData);
    opB = pickOperand(rtAddr, rtData, exFwdValid, exFwdReg, exFwdData,
                      resValid, resReg, resData);
  end

  // execute-input register
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      exValid     <= 1'b0;
      exRegWrite  <= 1'b0;
      exMemWrite  <= 1'b0;
      exMemToReg  <= 1'b0;
      exAluSrcImm <= 1'b0;
      exAluOp     <= AluAdd;
      exDest      <= '0;
      exOpA       <= '0;
      exOpB       <= '0;
      exImm       <= '0;
      exShamt     <= '0;
    end
    else
    begin
      exValid     <= decValid && known;
      exRegWrite  <= regWrite;
      exMemWrite  <= memWrite;
      exMemToReg  <= memToReg;
      exAluSrcImm <= aluSrcImm;
      exAluOp     <= aluOp;
      exDest      <= dest;
      exOpA       <= opA;
      exOpB       <= opB;  // also sw store data
      exImm       <= immExt;
      exShamt     <= decInstr.rFields.shamt;
    end
  end

endmodule

`default_nettype wire

// File: executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage import cpuPkg::*; #(
  parameter int MemDepth = 256
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    exValid,
  input  logic                    exRegWrite,
  input  logic                    exMemWrite,
  input  logic                    exMemToReg,
  input  logic                    exAluSrcImm,
  input  logic [AluOpWidth-1:0]   exAluOp,
  input  logic [RegAddrWidth-1:0] exDest,
  input  logic [DataWidth-1:0]    exOpA,
  input  logic [DataWidth-1:0]    exOpB,
  input  logic [DataWidth-1:0]    exImm,
  input  logic [4:0]              exShamt,
  output logic                    exFwdValid,
  output logic [RegAddrWidth-1:0] exFwdReg,
  output logic [DataWidth-1:0]    exFwdData,
  output logic                    resValid,
  output logic [RegAddrWidth-1:0] resReg,
  output logic [DataWidth-1:0]    resData
);

  localparam int AddrWidth = $clog2(MemDepth);

  logic [DataWidth-1:0] aluB;
  logic [DataWidth-1:0] aluRes;
  logic [DataWidth-1:0] memRdData;
  logic [AddrWidth-1:0] memAddr;
  logic                 memWrEn;

  always_comb
  begin
    aluB = exAluSrcImm ? exImm : exOpB;  // imm for lw/sw
    case (exAluOp)
      AluAdd:  aluRes = exOpA + aluB;
      AluSub:  aluRes = exOpA - aluB;
      AluAnd:  aluRes = exOpA & aluB;
      AluOr:   aluRes = exOpA | aluB;
      AluSll:  aluRes = exOpB << exShamt;  // shifts rt
      AluSrl:  aluRes = exOpA >> exShamt;  // shifts rs, as the old alu did
      default: aluRes = '0;
    endcase
  end

  // word address from the low alu bits
  assign memAddr = aluRes[AddrWidth-1:0];
  assign memWrEn = exValid && exMemWrite;  // bubbles never store

  dataMemory #(
    .MemDepth (MemDepth)
  ) u_dataMemory (
    .clk    (clk),
    .rst    (rst),
    .addr   (memAddr),
    .wrEn   (memWrEn),
    .wrData (exOpB),
    .rdData (memRdData)
  );

  // same value goes back to decode and into the result reg
  assign exFwdValid = exValid && exRegWrite;
  assign exFwdReg   = exDest;
  assign exFwdData  = exMemToReg ? memRdData : aluRes;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      resValid <= 1'b0;
      resReg   <= '0;
      resData  <= '0;
    end
    else
    begin
      resValid <= exFwdValid;  // only register writers complete
      resReg   <= exFwdReg;
      resData  <= exFwdData;
    end
  end

endmodule

`default_nettype wire

// File: resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage import cpuPkg::*; (
  input  logic                    resValid,
  input  logic [RegAddrWidth-1:0] resReg,
  input  logic [DataWidth-1:0]    resData,
  output logic                    wrEn,
  output logic [RegAddrWidth-1:0] wrAddr,
  output logic [DataWidth-1:0]    wrData,
  output logic                    wbValid,
  output logic [RegAddrWidth-1:0] wbReg,
  output logic [DataWidth-1:0]    wbData
);

  // resValid already means a completed register write
  // regfile just obeys wrEn
  assign wrEn   = resValid;
  assign wrAddr = resReg;
  assign wrData = resData;

  // observation port, quiet when nothing retires
  assign wbValid = resValid;
  assign wbReg   = resValid ? resReg : '0;
  assign wbData  = resValid ? resData : '0;

endmodule

`default_nettype wire

// File: pipeCpu.sv
`timescale 1ns/1ps
`default_nettype none

module pipeCpu import cpuPkg::*; #(
  parameter int MemDepth = 256
) (
  input  logic                    clk,
  input  logic                    rst,
  input  instrWord_t              instr,
  input  logic                    instrValid,
  output logic                    wbValid,
  output logic [RegAddrWidth-1:0] wbReg,
  output logic [DataWidth-1:0]    wbData
);

  // regfile ports
  logic [RegAddrWidth-1:0] rsAddr;
  logic [RegAddrWidth-1:0] rtAddr;
  logic [DataWidth-1:0]    rsData;
  logic [DataWidth-1:0]    rtData;
  logic                    wrEn;
  logic [RegAddrWidth-1:0] wrAddr;
  logic [DataWidth-1:0]    wrData;

  // decode -> execute
  logic                    exValid;
  logic                    exRegWrite;
  logic                    exMemWrite;
  logic                    exMemToReg;
  logic                    exAluSrcImm;
  logic [AluOpWidth-1:0]   exAluOp;
  logic [RegAddrWidth-1:0] exDest;
  logic [DataWidth-1:0]    exOpA;
  logic [DataWidth-1:0]    exOpB;
  logic [DataWidth-1:0]    exImm;
  logic [4:0]              exShamt;

  // forward paths and result register
  logic                    exFwdValid;
  logic [RegAddrWidth-1:0] exFwdReg;
  logic [DataWidth-1:0]    exFwdData;
  logic                    resValid;
  logic [RegAddrWidth-1:0] resReg;
  logic [DataWidth-1:0]    resData;

  decodeStage u_decodeStage (
    .clk (clk), .rst (rst), .instr (instr), .instrValid (instrValid),
    .rsAddr (rsAddr), .rtAddr (rtAddr), .rsData (rsData), .rtData (rtData),
    .exFwdValid (exFwdValid), .exFwdReg (exFwdReg), .exFwdData (exFwdData),
    .resValid (resValid), .resReg (resReg), .resData (resData),
    .exValid (exValid), .exRegWrite (exRegWrite), .exMemWrite (exMemWrite),
    .exMemToReg (exMemToReg), .exAluSrcImm (exAluSrcImm), .exAluOp (exAluOp),
    .exDest (exDest), .exOpA (exOpA), .exOpB (exOpB), .exImm (exImm),
    .exShamt (exShamt)
  );

  executeStage #(.MemDepth (MemDepth)) u_executeStage (
    .clk (clk), .rst (rst),
    .exValid (exValid), .exRegWrite (exRegWrite), .exMemWrite (exMemWrite),
    .exMemToReg (exMemToReg), .exAluSrcImm (exAluSrcImm), .exAluOp (exAluOp),
    .exDest (exDest), .exOpA (exOpA), .exOpB (exOpB), .exImm (exImm),
    .exShamt (exShamt),
    .exFwdValid (exFwdValid), .exFwdReg (exFwdReg), .exFwdData (exFwdData),
    .resValid (resValid), .resReg (resReg), .resData (resData)
  );

  resultStage u_resultStage (
    .resValid (resValid), .resReg (resReg), .resData (resData),
    .wrEn (wrEn), .wrAddr (wrAddr), .wrData (wrData),
    .wbValid (wbValid), .wbReg (wbReg), .wbData (wbData)
  );

  regFile u_regFile (
    .clk (clk), .rst (rst),
    .rsAddr (rsAddr), .rtAddr (rtAddr), .rsData (rsData), .rtData (rtData),
    .wrEn (wrEn), .wrAddr (wrAddr), .wrData (wrData)
  );

endmodule

`default_nettype wire

// File: tbProgram.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns: instruction word, writeback expected, expected wbReg, expected wbData
// start state r[i] = i and mem[i] = i
task automatic loadProgram();
  // alu ops on untouched registers
  addRow(encodeR(FnAdd, 5'd3, 5'd4, 5'd10, 5'd0), 1'b1, 5'd10, 32'd7);    // 3 + 4
  addRow(encodeR(FnSub, 5'd20, 5'd5, 5'd11, 5'd0), 1'b1, 5'd11, 32'd15);  // 20 - 5
  addRow(encodeR(FnAnd, 5'd13, 5'd7, 5'd12, 5'd0), 1'b1, 5'd12, 32'd5);   // 1101 & 0111
  addRow(encodeR(FnOr, 5'd8, 5'd6, 5'd13, 5'd0), 1'b1, 5'd13, 32'd14);    // 1000 | 0110
  // shifts, sll takes rt and srl takes rs
  addRow(encodeR(FnSll, 5'd0, 5'd5, 5'd14, 5'd3), 1'b1, 5'd14, 32'd40);   // 5 << 3
  addRow(encodeR(FnSrl, 5'd24, 5'd0, 5'd15, 5'd2), 1'b1, 5'd15, 32'd6);   // 24 >> 2
  // dependent chain
  addRow(encodeR(FnAdd, 5'd15, 5'd14, 5'd16, 5'd0), 1'b1, 5'd16, 32'd46); // 6 + 40
  addRow(encodeR(FnSub, 5'd16, 5'd12, 5'd17, 5'd0), 1'b1, 5'd17, 32'd41); // 46 - 5
  addRow(encodeR(FnOr, 5'd16, 5'd17, 5'd18, 5'd0), 1'b1, 5'd18, 32'd47);  // 46 | 41
  // same dest twice in flight, newest must win
  addRow(encodeR(FnAdd, 5'd1, 5'd2, 5'd19, 5'd0), 1'b1, 5'd19, 32'd3);
  addRow(encodeR(FnAdd, 5'd19, 5'd19, 5'd19, 5'd0), 1'b1, 5'd19, 32'd6);
  addRow(encodeR(FnAdd, 5'd19, 5'd1, 5'd20, 5'd0), 1'b1, 5'd20, 32'd7);   // 6 + 1
  // memory, store r10 (7) at word 5
  addRow(encodeI(OpSw, 5'd1, 5'd10, 16'd4), 1'b0, 5'd0, 32'd0);
  addRow(encodeI(OpLw, 5'd1, 5'd21, 16'd4), 1'b1, 5'd21, 32'd7);
  addRow(encodeI(OpLw, 5'd21, 5'd22, 16'd96), 1'b1, 5'd22, 32'd103);     // untouched word
  addRow(encodeI(OpLw, 5'd20, 5'd23, 16'hFFFE), 1'b1, 5'd23, 32'd7);     // 7 - 2 = word 5
  // not supported, both must vanish
  addRow(encodeI(6'h08, 5'd1, 5'd24, 16'd5), 1'b0, 5'd0, 32'd0);
  addRow(encodeR(6'h2A, 5'd1, 5'd2, 5'd25, 5'd0), 1'b0, 5'd0, 32'd0);
  addRow(encodeR(FnAdd, 5'd21, 5'd22, 5'd24, 5'd0), 1'b1, 5'd24, 32'd110); // 7 + 103
  addRow(encodeR(FnAdd, 5'd24, 5'd25, 5'd25, 5'd0), 1'b1, 5'd25, 32'd135); // r25 still 25
endtask

`endif

// File: tbPipeCpu.sv
`timescale 1ns/1ps
`default_nettype none

module tbPipeCpu import cpuPkg::*; ();

  logic                    clk = 1'b0;
  logic                    rst;
  instrWord_t              instr;
  logic                    instrValid;
  logic                    wbValid;
  logic [RegAddrWidth-1:0] wbReg;
  logic [DataWidth-1:0]    wbData;

  int unsigned cycleCnt;  // rising edges so far
  int          valueErrs;
  int          otherErrs;

  // program table filled by loadProgram
  instrWord_t              progInstr[$];
  bit                      progWb[$];
  logic [RegAddrWidth-1:0] progReg[$];
  logic [DataWidth-1:0]    progData[$];

  // writebacks in flight with oldest first
  logic [RegAddrWidth-1:0] expRegQ[$];
  logic [DataWidth-1:0]    expDataQ[$];
  int unsigned             expCycleQ[$];  // edge count at the negedge where wbValid should show

  // writebacks seen on the ports
  logic [RegAddrWidth-1:0] obsRegQ[$];
  logic [DataWidth-1:0]    obsDataQ[$];
  int unsigned             obsCycleQ[$];

  pipeCpu #(.MemDepth (256)) u_dut (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .instrValid (instrValid),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData)
  );

  function automatic instrWord_t encodeR(input logic [5:0] funct, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] shamt);
    instrWord_t w;
    w.rFields.opcode = OpRType;
    w.rFields.rs     = rs;
    w.rFields.rt     = rt;
    w.rFields.rd     = rd;
    w.rFields.shamt  = shamt;
    w.rFields.funct  = funct;
    return w;
  endfunction

  function automatic instrWord_t encodeI(input logic [5:0] opcode, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm16);
    instrWord_t w;
    w.iFields.opcode = opcode;
    w.iFields.rs     = rs;
    w.iFields.rt     = rt;
    w.iFields.imm16  = imm16;
    return w;
  endfunction

  task automatic addRow(input instrWord_t w, input bit wb, input logic [4:0] dst,
                        input logic [31:0] data);
    progInstr.push_back(w);
    progWb.push_back(wb);
    progReg.push_back(dst);
    progData.push_back(data);
  endtask

  `include "tbProgram.svh"

  // 40 ns clock
  initial
  begin
    cycleCnt = 0;
    forever
    begin
      #20;
      clk = ~clk;
      if (clk)
        cycleCnt++;
    end
  end

  // wbValid must stay low through the 10 reset cycles
  task automatic applyReset();
    rst = 1'b1;
    instrValid = 1'b0;
    repeat (10)
    begin
      @(negedge clk);
      assert (wbValid === 1'b0)
      else
      begin
        $display("FAILED at %0t: wbValid expected 0, got %b during reset", $time, wbValid);
        valueErrs++;
      end
    end
    rst = 1'b0;
  endtask

  // bubbles only so nothing may retire
  task automatic idleCycles(input int n);
    repeat (n)
    begin
      @(negedge clk);
      instrValid = 1'b0;
      assert (wbValid === 1'b0)
      else
      begin
        $display("FAILED at %0t: wbValid expected 0, got %b while idle", $time, wbValid);
        valueErrs++;
      end
    end
  endtask

  // one row per cycle with optional 0..2 bubbles after each row
  task automatic runProgram(input bit withBubbles);
    int unsigned rnd;
    for (int i = 0; i < progInstr.size(); i++)
    begin
      @(negedge clk);
      instr      = progInstr[i];
      instrValid = 1'b1;
      if (progWb[i])
      begin
        expRegQ.push_back(progReg[i]);
        expDataQ.push_back(progData[i]);
        expCycleQ.push_back(cycleCnt + 3);  // sampled at next edge and shows two edges later
      end
      if (withBubbles)
      begin
        rnd = $urandom;
        repeat (rnd % 3)
        begin
          @(negedge clk);
          instrValid = 1'b0;  // previous word held with valid low
        end
      end
    end
    @(negedge clk);
    instr      = '0;
    instrValid = 1'b0;
  endtask

  task automatic waitDrain(input int limit);
    int waited;
    waited = 0;
    while (expRegQ.size() > 0 && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    assert (expRegQ.size() == 0)
    else
    begin
      $display("timeout: %0d expected writebacks never appeared within %0d cycles",
               expRegQ.size(), limit);
      otherErrs++;
      expRegQ.delete();
      expDataQ.delete();
      expCycleQ.delete();
    end
  endtask

  // writeback monitor samples on the falling edge where wb* are stable
  initial
  begin : wbMonitor
    logic [4:0]  oReg;
    logic [31:0] oData;
    int unsigned oCycle;
    logic [4:0]  eReg;
    logic [31:0] eData;
    int unsigned eCycle;
    forever
    begin
      @(negedge clk);
      if (wbValid === 1'b1)
      begin
        obsRegQ.push_back(wbReg);
        obsDataQ.push_back(wbData);
        obsCycleQ.push_back(cycleCnt);
      end
      while (obsRegQ.size() > 0)
      begin
        oReg   = obsRegQ.pop_front();
        oData  = obsDataQ.pop_front();
        oCycle = obsCycleQ.pop_front();
        assert (expRegQ.size() > 0)
        else
        begin
          $display("unexpected writeback at %0t: r%0d = %0d with nothing pending",
                   $time, oReg, oData);
          otherErrs++;
        end
        if (expRegQ.size() > 0)
        begin
          eReg   = expRegQ.pop_front();
          eData  = expDataQ.pop_front();
          eCycle = expCycleQ.pop_front();
          assert (oReg == eReg)
          else
          begin
            $display("FAILED at %0t: wbReg expected %0d, got %0d", $time, eReg, oReg);
            valueErrs++;
          end
          assert (oData == eData)
          else
          begin
            $display("FAILED at %0t: wbData expected %0d, got %0d", $time, eData, oData);
            valueErrs++;
          end
          assert (oCycle == eCycle)  // two edges after input sampling
          else
          begin
            $display("FAILED at %0t: wbValid cycle expected %0d, got %0d", $time, eCycle,
                     oCycle);
            valueErrs++;
          end
        end
      end
    end
  end

  initial
  begin
    rst        = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    valueErrs  = 0;
    otherErrs  = 0;
    void'($urandom(32'h6fd4fe6e));
    loadProgram();
    applyReset();
    idleCycles(5);
    runProgram(1'b0);  // back to back for forwarding at distance one and two
    waitDrain(20);
    idleCycles(4);
    applyReset();      // fresh state and the same program with gaps
    runProgram(1'b1);
    waitDrain(20);
    idleCycles(4);
    $display("error count: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
cpuPkg.sv
regFile.sv
dataMemory.sv
decodeStage.sv
executeStage.sv
resultStage.sv
pipeCpu.sv
tbPipeCpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tbPipeCpu -o simPipeCpu
./obj_dir/simPipeCpu > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
